// ==== hdl/dds_mod_params.svh ====
`ifndef DDS_MOD_PARAMS_SVH
`define DDS_MOD_PARAMS_SVH

////////////////////
// widths

// phase accumulator whose top bits address the tables
`define DDS_PHASE_W 32

`define DDS_SAMPLE_W 12 // signed samples
`define DDS_SYMBOL_W 5  // lfsr state

////////////////////
// defaults

// one symbol per second on the 25 MHz clock
`define DDS_SYMBOL_PERIOD 25000000

`define DDS_FULL_SCALE 2047 // largest magnitude so +/- stay symmetric

// lfsr must never sit at all zeros
`define DDS_LFSR_SEED 1

`endif

// ==== hdl/dds_mod_pkg.sv ====
`include "dds_mod_params.svh"

package dds_mod_pkg;

   typedef logic [`DDS_PHASE_W-1:0] phase_t;
   typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;
   typedef logic [`DDS_SYMBOL_W-1:0] symbol_t;

   // carrier choice
   typedef enum logic [1:0] {
      wave_sin,
      wave_cos,
      wave_saw,
      wave_square
   } wave_sel_e;

   typedef enum logic [1:0] {
      mod_ask,
      mod_fsk,
      mod_bpsk,
      mod_lfsr // baseband symbol level
   } mod_sel_e;

   typedef struct packed {
      wave_sel_e wave_sel;
      mod_sel_e  mod_sel;
      logic      qpsk; // overrides mod_sel when set
   } mod_cfg_t;

   // symbol rides with the phase it produced
   typedef struct packed {
      phase_t  phase;
      symbol_t symbol;
   } phase_stage_t;

   typedef struct packed {
      sample_t sine;
      sample_t cosine;
      sample_t saw;
      sample_t square;
      symbol_t symbol;
   } wave_stage_t;

endpackage

// ==== hdl/symbol_source.sv ====
`timescale 1ns/1ps
`include "dds_mod_params.svh"

module symbol_source #(
   parameter int symbol_period = `DDS_SYMBOL_PERIOD
) (
   input  logic                 CLK_25MHZ,
   input  logic                 reset_from_key,
   output dds_mod_pkg::symbol_t symbol
);
   import dds_mod_pkg::*;

   localparam int CNT_W = (symbol_period > 1) ? $clog2(symbol_period) : 1;

   logic [CNT_W-1:0] tick_cnt;
   logic             tick_wrap;
   symbol_t          lfsr;

   assign tick_wrap = (tick_cnt == CNT_W'(symbol_period - 1));

   ////////////////////
   // symbol strobe

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         tick_cnt <= '0;
      else if (tick_wrap)
         tick_cnt <= '0;
      else
         tick_cnt <= tick_cnt + 1'b1;
   end

   // fibonacci on taps 5 and 3 -> 31 states
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr <= symbol_t'(`DDS_LFSR_SEED);
      else if (tick_wrap)
         lfsr <= {lfsr[3:0], lfsr[4] ^ lfsr[2]};
   end

   assign symbol = lfsr;

endmodule

// ==== hdl/phase_accumulator.sv ====
`timescale 1ns/1ps

module phase_accumulator (
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  dds_mod_pkg::mod_cfg_t     cfg,
   input  dds_mod_pkg::phase_t       inc_low,
   input  dds_mod_pkg::phase_t       inc_high,
   input  dds_mod_pkg::symbol_t      symbol,
   output dds_mod_pkg::phase_stage_t phase_stage
);
   import dds_mod_pkg::*;

   phase_t inc;
   logic   use_high;

   // only plain fsk hops frequency while qpsk keeps the low carrier
   assign use_high = (cfg.mod_sel == mod_fsk) && !cfg.qpsk && symbol[0];
   assign inc      = use_high ? inc_high : inc_low;

   ////////////////////
   // phase register

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase_stage <= '0;
      end
      else
      begin
         phase_stage.phase  <= phase_stage.phase + inc; // wraps mod 2^32
         phase_stage.symbol <= symbol;                  // symbol that picked inc
      end
   end

endmodule

// ==== hdl/waveform_lookup.sv ====
`timescale 1ns/1ps
`include "dds_mod_params.svh"

module waveform_lookup (
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  dds_mod_pkg::phase_stage_t phase_stage,
   output dds_mod_pkg::wave_stage_t  wave_stage
);
   import dds_mod_pkg::*;

   localparam int  QTR_N = 64;
   localparam int  MAG_W = `DDS_SAMPLE_W - 1;
   localparam real PI    = 3.14159265358979323846;

   typedef logic [QTR_N-1:0][MAG_W-1:0] qtab_t;

   ////////////////////
   // quarter-wave table

   // sampled at bin centres so the four quarters mirror cleanly
   function automatic qtab_t build_qtab();
      qtab_t t;
      real   ang;
      for (int k = 0; k < QTR_N; k++)
      begin
         ang  = 2.0 * PI * (real'(k) + 0.5) / 256.0;
         t[k] = MAG_W'($rtoi(real'(`DDS_FULL_SCALE) * $sin(ang) + 0.5));
      end
      return t;
   endfunction

   localparam qtab_t QTAB = build_qtab();

   function automatic sample_t sin_lookup(input logic [7:0] p);
      logic [5:0] idx;
      sample_t    mag;
      idx = p[6] ? ~p[5:0] : p[5:0]; // 63-k on the falling quarters
      mag = sample_t'({1'b0, QTAB[idx]});
      return p[7] ? -mag : mag;       // second half is negative
   endfunction

   logic [7:0]  addr;
   wave_stage_t wave_next;

   assign addr = phase_stage.phase[`DDS_PHASE_W-1 -: 8];

   always_comb
   begin
      wave_next.sine   = sin_lookup(addr);
      wave_next.cosine = sin_lookup(addr + 8'd64); // quarter turn ahead
      wave_next.saw    = sample_t'(phase_stage.phase[`DDS_PHASE_W-1 -: `DDS_SAMPLE_W]);
      if (phase_stage.phase[`DDS_PHASE_W-1])
         wave_next.square = sample_t'(-`DDS_FULL_SCALE);
      else
         wave_next.square = sample_t'(`DDS_FULL_SCALE);
      wave_next.symbol = phase_stage.symbol;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         wave_stage <= '0;
      else
         wave_stage <= wave_next;
   end

endmodule

// ==== hdl/modulator.sv ====
`timescale 1ns/1ps
`include "dds_mod_params.svh"

module modulator (
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  dds_mod_pkg::mod_cfg_t    cfg,
   input  dds_mod_pkg::wave_stage_t wave_stage,
   output dds_mod_pkg::sample_t     signal_out,
   output dds_mod_pkg::sample_t     modulated_out,
   output dds_mod_pkg::symbol_t     symbol_out
);
   import dds_mod_pkg::*;

   localparam sample_t POS_FS = sample_t'(`DDS_FULL_SCALE);
   localparam sample_t NEG_FS = sample_t'(-`DDS_FULL_SCALE);

   // -2048 has no positive twin so it clamps
   function automatic sample_t neg_sat(input sample_t x);
      return (x == sample_t'(-`DDS_FULL_SCALE - 1)) ? POS_FS : -x;
   endfunction

   sample_t carrier;
   sample_t mod_next;
   logic    bit0;

   assign bit0 = wave_stage.symbol[0];

   ////////////////////
   // carrier select

   always_comb
   begin
      case (cfg.wave_sel)
         wave_sin: carrier = wave_stage.sine;
         wave_cos: carrier = wave_stage.cosine;
         wave_saw: carrier = wave_stage.saw;
         default:  carrier = wave_stage.square;
      endcase
   end

   always_comb
   begin
      if (cfg.qpsk)
      begin
         case (wave_stage.symbol[1:0]) // four phases from two bits
            2'b00:   mod_next = wave_stage.cosine;
            2'b01:   mod_next = wave_stage.sine;
            2'b10:   mod_next = neg_sat(wave_stage.cosine);
            default: mod_next = neg_sat(wave_stage.sine);
         endcase
      end
      else
      begin
         case (cfg.mod_sel)
            mod_ask:  mod_next = bit0 ? carrier : '0;
            mod_fsk:  mod_next = carrier; // hop already done in phase
            mod_bpsk: mod_next = bit0 ? carrier : neg_sat(carrier);
            default:  mod_next = bit0 ? POS_FS : NEG_FS;
         endcase
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         signal_out    <= '0;
         modulated_out <= '0;
         symbol_out    <= '0;
      end
      else
      begin
         signal_out    <= carrier;
         modulated_out <= mod_next;
         symbol_out    <= wave_stage.symbol; // led view
      end
   end

endmodule

// ==== hdl/dds_mod_top.sv ====
`timescale 1ns/1ps
`include "dds_mod_params.svh"

module dds_mod_top #(
   parameter int symbol_period = `DDS_SYMBOL_PERIOD
) (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_mod_pkg::mod_cfg_t cfg,
   input  dds_mod_pkg::phase_t   inc_low,
   input  dds_mod_pkg::phase_t   inc_high,
   output dds_mod_pkg::sample_t  signal_out,
   output dds_mod_pkg::sample_t  modulated_out,
   output dds_mod_pkg::symbol_t  symbol_out
);
   import dds_mod_pkg::*;

   symbol_t      symbol;
   phase_stage_t phase_stage;
   wave_stage_t  wave_stage;

   ////////////////////
   // pipeline stages

   symbol_source #(
      .symbol_period (symbol_period)
   ) u_symbol_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .symbol         (symbol)
   );

   // fsk hop happens here
   phase_accumulator u_phase_accumulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .cfg            (cfg),
      .inc_low        (inc_low),
      .inc_high       (inc_high),
      .symbol         (symbol),
      .phase_stage    (phase_stage)
   );

   waveform_lookup u_waveform_lookup (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_stage    (phase_stage),
      .wave_stage     (wave_stage)
   );

   modulator u_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .cfg            (cfg),
      .wave_stage     (wave_stage),
      .signal_out     (signal_out),
      .modulated_out  (modulated_out),
      .symbol_out     (symbol_out)
   );

endmodule

// ==== verif/dds_mod_tb.sv ====
`timescale 1ns/1ps
`include "dds_mod_params.svh"

module dds_mod_tb;
   import dds_mod_pkg::*;

   localparam int  SYM_PERIOD = 8;
   localparam real PI         = 3.14159265358979323846;

   // one line of the vector file
   typedef struct packed {
      logic [1:0]  wave;
      logic [1:0]  mode;
      logic        qpsk;
      phase_t      inc_low;
      phase_t      inc_high;
      logic [31:0] cycles;
      symbol_t     exp_sym;
   } vec_t;

   logic     CLK_25MHZ;
   logic     reset_from_key;
   mod_cfg_t cfg;
   phase_t   inc_low;
   phase_t   inc_high;
   sample_t  signal_out;
   sample_t  modulated_out;
   symbol_t  symbol_out;

   vec_t vecs[$];
   int   errors    = 0;
   int   checks    = 0;
   int   wd_cycles = 0;

   dds_mod_top #(
      .symbol_period (SYM_PERIOD)
   ) uut (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .cfg            (cfg),
      .inc_low        (inc_low),
      .inc_high       (inc_high),
      .signal_out     (signal_out),
      .modulated_out  (modulated_out),
      .symbol_out     (symbol_out)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ; // 25 MHz
   end

   ////////////////////
   // reference model

   function automatic symbol_t next_lfsr(input symbol_t s);
      return {s[3:0], s[4] ^ s[2]};
   endfunction

   function automatic symbol_t lfsr_after(input int steps);
      symbol_t s;
      s = symbol_t'(`DDS_LFSR_SEED);
      for (int i = 0; i < steps; i++)
         s = next_lfsr(s);
      return s;
   endfunction

   // bin-centre sine straight from the formula
   function automatic int sine_model(input logic [7:0] a);
      real v;
      real mag;
      int  r;
      v   = real'(`DDS_FULL_SCALE) * $sin(2.0 * PI * (real'(int'(a)) + 0.5) / 256.0);
      mag = (v < 0.0) ? -v : v;
      r   = $rtoi(mag + 0.5);
      return (v < 0.0) ? -r : r;
   endfunction

   function automatic int carrier_model(input logic [1:0] wave, input phase_t p);
      logic [7:0] a;
      logic [7:0] ca;
      a  = p[31:24];
      ca = a + 8'd64; // cosine is a quarter turn on
      case (wave)
         2'd0:    return sine_model(a);
         2'd1:    return sine_model(ca);
         2'd2:    return int'($signed(p[31:20]));
         default: return p[31] ? -`DDS_FULL_SCALE : `DDS_FULL_SCALE;
      endcase
   endfunction

   function automatic int negate_sat(input int x);
      return (x == -`DDS_FULL_SCALE - 1) ? `DDS_FULL_SCALE : -x;
   endfunction

   function automatic int modulated_model(input vec_t v, input phase_t p, input symbol_t s);
      int car;
      car = carrier_model(v.wave, p);
      if (v.qpsk)
      begin
         case (s[1:0])
            2'd0:    return carrier_model(2'd1, p);
            2'd1:    return carrier_model(2'd0, p);
            2'd2:    return negate_sat(carrier_model(2'd1, p));
            default: return negate_sat(carrier_model(2'd0, p));
         endcase
      end
      case (v.mode)
         2'd0:    return s[0] ? car : 0;
         2'd1:    return car;
         2'd2:    return s[0] ? car : negate_sat(car);
         default: return s[0] ? `DDS_FULL_SCALE : -`DDS_FULL_SCALE;
      endcase
   endfunction

   ////////////////////
   // checks

   task automatic compare_sample(input string name, input sample_t got, input int exp_val);
      checks++;
      if (got !== sample_t'(exp_val))
      begin
         errors++;
         $display("FAILED %0t ns: %s expected %0d got %0d", $time, name, exp_val, got);
      end
   endtask

   task automatic verify_symbol(input string name, input symbol_t got, input symbol_t exp_val);
      checks++;
      if (got !== exp_val)
      begin
         errors++;
         $display("FAILED %0t ns: %s expected %0h got %0h", $time, name, exp_val, got);
      end
   endtask

   task automatic load_vectors();
      int      fd;
      int      n;
      int      wave;
      int      mode;
      int      qpsk;
      int      cycles;
      phase_t  lo;
      phase_t  hi;
      symbol_t es;
      string   line;
      vec_t    v;
      fd = $fopen("verif/dds_mod_vectors.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("could not open verif/dds_mod_vectors.txt");
         return;
      end
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() == 0 || line.getc(0) == "#")
            continue;
         n = $sscanf(line, "%d %d %d %h %h %d %h", wave, mode, qpsk, lo, hi, cycles, es);
         if (n == 7)
         begin
            v = {wave[1:0], mode[1:0], qpsk[0], lo, hi, cycles, es};
            vecs.push_back(v);
         end
         else if (n > 0)
         begin
            errors++;
            $display("malformed line in vector file: %s", line);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_vector(input vec_t v, input int rst_cycles);
      phase_t  m_phase;
      symbol_t m_lfsr;
      int      m_tick;
      phase_t  hist_phase[$];
      symbol_t hist_sym[$];
      phase_t  p;
      symbol_t s;
      logic    use_hi;
      int      t;
      reset_from_key = 1'b1;
      cfg.wave_sel   = wave_sel_e'(v.wave);
      cfg.mod_sel    = mod_sel_e'(v.mode);
      cfg.qpsk       = v.qpsk;
      inc_low        = v.inc_low;
      inc_high       = v.inc_high;
      repeat (rst_cycles) @(posedge CLK_25MHZ);
      #1;
      compare_sample("signal_out", signal_out, 0);
      compare_sample("modulated_out", modulated_out, 0);
      verify_symbol("symbol_out", symbol_out, '0);
      #1;
      reset_from_key = 1'b0;
      m_phase = '0;
      m_lfsr  = symbol_t'(`DDS_LFSR_SEED);
      m_tick  = 0;
      hist_phase.push_back('0); // stage registers start at zero
      hist_sym.push_back('0);
      for (t = 1; t <= int'(v.cycles); t++)
      begin
         @(posedge CLK_25MHZ);
         #1;
         use_hi  = (v.mode == 2'd1) && !v.qpsk && m_lfsr[0];
         m_phase = m_phase + (use_hi ? v.inc_high : v.inc_low);
         hist_phase.push_back(m_phase);
         hist_sym.push_back(m_lfsr); // symbol that chose the increment
         if (m_tick == SYM_PERIOD - 1)
         begin
            m_lfsr = next_lfsr(m_lfsr);
            m_tick = 0;
         end
         else
            m_tick++;
         if (t >= 2) // outputs show the pair from two edges back
         begin
            p = hist_phase[t-2];
            s = hist_sym[t-2];
            compare_sample("signal_out", signal_out, carrier_model(v.wave, p));
            compare_sample("modulated_out", modulated_out, modulated_model(v, p, s));
            verify_symbol("symbol_out", symbol_out, s);
         end
         #1;
      end
      verify_symbol("final symbol_out", symbol_out, v.exp_sym);
   endtask

   ////////////////////
   // main sequence

   initial
   begin
      int   i;
      int   total;
      vec_t extra;
      reset_from_key = 1'b1;
      cfg            = '0;
      inc_low        = '0;
      inc_high       = '0;
      void'($urandom(18));
      load_vectors();
      if (vecs.size() == 0)
      begin
         errors++;
         $display("no test vectors were read");
      end
      // fsk with random increments so both of them are used
      extra.wave     = 2'($urandom_range(3, 0));
      extra.mode     = 2'd1;
      extra.qpsk     = 1'b0;
      extra.inc_low  = $urandom();
      extra.inc_high = $urandom();
      extra.cycles   = 160;
      extra.exp_sym  = lfsr_after((160 - 3) / SYM_PERIOD);
      vecs.push_back(extra);
      total = 0;
      foreach (vecs[k])
         total += int'(vecs[k].cycles);
      wd_cycles = (total + 18 * vecs.size()) * 2;
      for (i = 0; i < vecs.size(); i++)
         run_vector(vecs[i], (i == 0) ? 16 : 2);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   initial
   begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge CLK_25MHZ);
      $display("watchdog expired after %0d cycles, run did not complete", wd_cycles);
      $display("TB FAILED");
      $finish;
   end

endmodule

// ==== verif/dds_mod_vectors.txt ====
# wave mode qpsk inc_low inc_high cycles exp_symbol
# wave 0-3 sin cos saw square, mode 0-3 ask fsk bpsk lfsr, increments and symbol in hex
0 0 0 01000000 02000000 100 0f
1 0 0 00c00000 02000000 120 1e
2 0 0 00400000 00800000 64 16
3 0 0 00800000 01000000 80 19
0 2 0 01000000 02000000 100 0f
2 2 0 01000000 02000000 150 03
2 1 0 00400000 00900000 200 1d
0 1 0 00800000 01800000 180 17
3 1 0 00200000 00600000 96 07
0 0 1 00c00000 00000000 140 11
2 1 1 00500000 03000000 90 13
1 3 0 00300000 00000000 60 16
0 3 0 01000000 00000000 260 02
3 0 0 ffff0000 00010000 45 05

// ==== dds_mod.f ====
+incdir+hdl
hdl/dds_mod_pkg.sv
hdl/symbol_source.sv
hdl/phase_accumulator.sv
hdl/waveform_lookup.sv
hdl/modulator.sv
hdl/dds_mod_top.sv
verif/dds_mod_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dds modulator testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module dds_mod_tb -f dds_mod.f -o dds_mod_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/dds_mod_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
